//--- logic/gfxPkg.sv
`default_nettype none

package gfxPkg;

	////////////////////////////////////////
	// Display geometry
	////////////////////////////////////////
	localparam int screenWidth = 160;	// Columns per row
	localparam int screenHeight = 120;	// Rows per frame
	localparam int pixelAddrWidth = 15;	// Holds row * 160 + col
	localparam int colorWidth = 3;		// One bit each for R, G, B

	////////////////////////////////////////
	// Command and pixel buses
	////////////////////////////////////////

	// Span word as pushed by the CPU, MSB first
	typedef struct packed {
		logic [5:0] pad;			// Ignored
		logic [colorWidth-1:0] color;
		logic [6:0] row;			// 0-119 on screen
		logic [7:0] left;			// First column, inclusive
		logic [7:0] right;			// Last column, inclusive
	} spanCmd;

	// All ones ends the frame and asks for a flip
	localparam logic [31:0] swapWord = 32'hFFFF_FFFF;

	// One pixel toward the back buffer
	typedef struct packed {
		logic we;
		logic [pixelAddrWidth-1:0] addr;	// Linear, row major
		logic [colorWidth-1:0] color;
	} pixelWrite;

	////////////////////////////////////////
	// Painter FSM
	////////////////////////////////////////
	typedef enum logic [2:0] {
		waitCmd,	// Idle until the FIFO holds a word
		fetch,		// FIFO read data arriving
		decode,		// Latch fields, or catch a swap
		paint,		// One pixel per clock
		waitSwap	// Parked until the flip is done
	} painterState;

endpackage

`default_nettype wire

//--- logic/spanFifo.sv
`default_nettype none

module spanFifo #(
	parameter int fifoDepth = 16	// Power of two
) (
	input logic clk,
	input logic reset,
	input logic push,
	input gfxPkg::spanCmd pushData,
	input logic pop,
	output gfxPkg::spanCmd popData,
	output logic empty,
	output logic full
);

	localparam int ptrWidth = $clog2(fifoDepth);

	gfxPkg::spanCmd store [fifoDepth];	// Circular command storage
	logic [ptrWidth-1:0] wrPtr;			// Next free slot
	logic [ptrWidth-1:0] rdPtr;			// Head of queue
	logic [ptrWidth:0] count;			// 0 up to fifoDepth
	logic doPush;
	logic doPop;

	// Qualified strobes
	assign doPush = push && !full;		// Overflow push is dropped
	assign doPop = pop && !empty;

	// Levels follow the count, so they move the cycle after a push or pop
	assign empty = (count == '0);
	assign full = (count == fifoDepth[ptrWidth:0]);

	////////////////////////////////////////
	// Pointers and occupancy
	////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (doPush)
				wrPtr <= wrPtr + 1'b1;	// Wraps at depth
			if (doPop)
				rdPtr <= rdPtr + 1'b1;
			case ({doPush, doPop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;	// Both or neither
			endcase
		end
	end

	////////////////////////////////////////
	// Storage and read register
	////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (doPush)
			store[wrPtr] <= pushData;
		// Head word shows up one cycle after pop
		if (doPop)
			popData <= store[rdPtr];
	end

endmodule

`default_nettype wire

//--- logic/spanPainter.sv
`default_nettype none

module spanPainter (
	input logic clk,
	input logic reset,
	input logic empty,
	input gfxPkg::spanCmd popData,
	output logic pop,
	output gfxPkg::pixelWrite pixelOut,
	output logic swapRequest,
	input logic swapDone,
	output logic swapPending
);

	gfxPkg::painterState state;

	// Latched span fields
	logic [gfxPkg::colorWidth-1:0] cmdColor;
	logic [6:0] cmdRow;
	logic [7:0] cmdRight;

	// Walking position
	logic [7:0] col;							// Current column
	logic [gfxPkg::pixelAddrWidth-1:0] addr;	// Current linear address

	logic [gfxPkg::pixelAddrWidth-1:0] rowBase;
	logic isSwap;
	logic emptySpan;
	logic lastPixel;
	logic onScreen;

	// Decode helpers, all looking at the FIFO read register
	assign isSwap = (popData == gfxPkg::swapWord);
	assign emptySpan = (popData.left > popData.right);	// Nothing to draw

	// row * 160 as row * 128 + row * 32
	assign rowBase = {1'b0, popData.row, 7'b0} + {3'b0, popData.row, 5'b0};

	assign lastPixel = (col == cmdRight);
	// Off-screen pixels still take their cycle but write nothing
	assign onScreen = (col < gfxPkg::screenWidth) && (cmdRow < gfxPkg::screenHeight);

	////////////////////////////////////////
	// Control outputs
	////////////////////////////////////////
	assign pop = (state == gfxPkg::waitCmd) && !empty;			// Single cycle, leaves waitCmd
	assign swapRequest = (state == gfxPkg::decode) && isSwap;	// One-cycle flip request

	// High from the request until the flip lands
	assign swapPending = swapRequest || (state == gfxPkg::waitSwap);

	always_comb
	begin
		pixelOut.we = (state == gfxPkg::paint) && onScreen;
		pixelOut.addr = addr;
		pixelOut.color = cmdColor;
	end

	////////////////////////////////////////
	// State register
	////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (reset)
			state <= gfxPkg::waitCmd;
		else
		begin
			case (state)
				gfxPkg::waitCmd:
				begin
					if (!empty)
						state <= gfxPkg::fetch;	// pop goes out this cycle
				end

				gfxPkg::fetch:
					state <= gfxPkg::decode;	// Read data valid next

				gfxPkg::decode:
				begin
					if (isSwap)
						state <= gfxPkg::waitSwap;
					else if (emptySpan)
						state <= gfxPkg::waitCmd;	// Skip, no pixels
					else
						state <= gfxPkg::paint;
				end

				gfxPkg::paint:
				begin
					if (lastPixel)
						state <= gfxPkg::waitCmd;	// Right end is inclusive
				end

				gfxPkg::waitSwap:
				begin
					// Resume once the buffers have flipped
					if (swapDone)
						state <= gfxPkg::waitCmd;
				end

				default:
					state <= gfxPkg::waitCmd;
			endcase
		end
	end

	////////////////////////////////////////
	// Span datapath
	////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (state == gfxPkg::decode)
		begin
			cmdColor <= popData.color;
			cmdRow <= popData.row;
			cmdRight <= popData.right;
			col <= popData.left;
			addr <= rowBase + {7'b0, popData.left};	// First pixel of span
		end
		else if (state == gfxPkg::paint)
		begin
			// Step one pixel to the right
			col <= col + 1'b1;
			addr <= addr + 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- logic/frameBuffers.sv
`default_nettype none

module frameBuffers (
	input logic clk,
	input logic reset,
	input gfxPkg::pixelWrite pixelIn,
	input logic swapRequest,
	input logic vBlank,
	output logic swapDone,
	input logic [gfxPkg::pixelAddrWidth-1:0] scanAddr,
	output logic [gfxPkg::colorWidth-1:0] scanPixel
);

	localparam int pixelCount = gfxPkg::screenWidth * gfxPkg::screenHeight;	// 19200

	logic frontSel;		// Buffer shown on the display
	logic readSel;		// frontSel at the time of the scan read
	logic waiting;		// Flip armed, no vBlank seen yet
	logic writeOk;
	logic scanOk;
	logic [gfxPkg::colorWidth-1:0] bankRead [2];

	// Out-of-range addresses fall on the floor
	assign writeOk = pixelIn.we && (pixelIn.addr < pixelCount);
	assign scanOk = (scanAddr < pixelCount);

	// Flip happens on the edge that ends this cycle
	assign swapDone = waiting && vBlank;

	////////////////////////////////////////
	// Swap control
	////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			frontSel <= 1'b0;	// Buffer 0 shown first
			waiting <= 1'b0;
			readSel <= 1'b0;
		end
		else
		begin
			readSel <= frontSel;
			if (swapDone)
			begin
				frontSel <= ~frontSel;	// Back becomes front
				waiting <= 1'b0;
			end
			else if (swapRequest)
				waiting <= 1'b1;	// Hold until vertical blank
		end
	end

	////////////////////////////////////////
	// Pixel memories
	////////////////////////////////////////
	for (genvar b = 0; b < 2; b++)
	begin : bank
		localparam logic bankId = (b == 1);

		logic [gfxPkg::colorWidth-1:0] mem [pixelCount];
		logic [gfxPkg::colorWidth-1:0] rdData;

		always_ff @(posedge clk)
		begin
			// Only the back buffer takes painter writes
			if (writeOk && (frontSel != bankId))
				mem[pixelIn.addr] <= pixelIn.color;
			if (scanOk)
				rdData <= mem[scanAddr];
			else
				rdData <= '0;	// Past the last pixel reads black
		end

		assign bankRead[b] = rdData;
	end

	// Pick whichever bank was front when the read was taken
	assign scanPixel = bankRead[readSel];

endmodule

`default_nettype wire

//--- logic/graphicsCore.sv
`default_nettype none

module graphicsCore #(
	parameter int fifoDepth = 16	// Span commands buffered
) (
	input logic clk,
	input logic reset,
	input logic cmdPush,
	input gfxPkg::spanCmd cmdData,
	output logic cmdFull,
	input logic vBlank,
	input logic [gfxPkg::pixelAddrWidth-1:0] scanAddr,
	output logic [gfxPkg::colorWidth-1:0] scanPixel,
	output logic swapPending
);

	////////////////////////////////////////
	// Internal nets
	////////////////////////////////////////
	logic fifoEmpty;
	logic fifoPop;
	gfxPkg::spanCmd fifoData;		// Head word toward painter
	gfxPkg::pixelWrite pixelBus;	// Painter to back buffer
	logic swapRequest;
	logic swapDone;

	// CPU side command queue
	spanFifo #(
		.fifoDepth(fifoDepth)
	) cmdFifo (
		.clk(clk),
		.reset(reset),
		.push(cmdPush),
		.pushData(cmdData),
		.pop(fifoPop),
		.popData(fifoData),
		.empty(fifoEmpty),
		.full(cmdFull)
	);

	// Span walker
	spanPainter painter (
		.clk(clk),
		.reset(reset),
		.empty(fifoEmpty),
		.popData(fifoData),
		.pop(fifoPop),
		.pixelOut(pixelBus),
		.swapRequest(swapRequest),
		.swapDone(swapDone),
		.swapPending(swapPending)
	);

	// Front/back pair with scan port
	frameBuffers buffers (
		.clk(clk),
		.reset(reset),
		.pixelIn(pixelBus),
		.swapRequest(swapRequest),
		.vBlank(vBlank),
		.swapDone(swapDone),
		.scanAddr(scanAddr),
		.scanPixel(scanPixel)
	);

endmodule

`default_nettype wire

//--- bench/tbModel.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

////////////////////////////////////////
// Stimulus helpers
////////////////////////////////////////
logic [31:0] rngState = 32'h7e60;

function automatic logic [31:0] nextRandom();
	logic [31:0] x;
	x = rngState;
	x = x ^ (x << 13);	// xorshift32
	x = x ^ (x >> 17);
	x = x ^ (x << 5);
	rngState = x;
	return x;
endfunction

function automatic gfxPkg::spanCmd makeSpan(input int color, input int row,
	input int left, input int right);
	gfxPkg::spanCmd cmd;
	cmd.pad = '0;	// Keeps it apart from the swap word
	cmd.color = 3'(color);
	cmd.row = 7'(row);
	cmd.left = 8'(left);
	cmd.right = 8'(right);
	return cmd;
endfunction

////////////////////////////////////////
// Two-buffer reference model
////////////////////////////////////////
logic [2:0] modelBuf [2][gfxPkg::screenWidth * gfxPkg::screenHeight];
int writeSel = 1;	// Back buffer, flips with each swap word
int shownSel = 0;	// Buffer the display sees, flips on vBlank

function automatic void applyCmd(input gfxPkg::spanCmd cmd);
	int c;
	int base;
	if (cmd == gfxPkg::swapWord)
		writeSel = 1 - writeSel;
	else if (cmd.row < gfxPkg::screenHeight)
	begin
		base = cmd.row * gfxPkg::screenWidth;
		// Both ends inclusive, left past right draws nothing
		for (c = cmd.left; c <= cmd.right; c++)
			if (c < gfxPkg::screenWidth)
				modelBuf[writeSel][base + c] = cmd.color;
	end
endfunction

function automatic logic [2:0] expectedPixel(input int addr);
	if (addr >= gfxPkg::screenWidth * gfxPkg::screenHeight)
		return '0;	// Past the last pixel reads black
	return modelBuf[shownSel][addr];
endfunction

`endif

//--- bench/graphicsCoreTb.sv
`default_nettype none

module graphicsCoreTb;

	localparam int fifoDepth = 16;

	logic clk;
	logic reset;
	logic cmdPush;
	gfxPkg::spanCmd cmdData;
	logic cmdFull;
	logic vBlank;
	logic [gfxPkg::pixelAddrWidth-1:0] scanAddr;
	logic [gfxPkg::colorWidth-1:0] scanPixel;
	logic swapPending;

	logic scanEnable;			// Readback in progress
	logic checkOn = 1'b0;		// scanPixel due this cycle
	logic [gfxPkg::pixelAddrWidth-1:0] checkAddr;
	string testName = "reset";
	int workCycles = 0;			// Cycles the queued work should need
	int cycleCount = 0;

	`include "tbModel.svh"

	graphicsCore #(
		.fifoDepth(fifoDepth)
	) uut (
		.clk(clk),
		.reset(reset),
		.cmdPush(cmdPush),
		.cmdData(cmdData),
		.cmdFull(cmdFull),
		.vBlank(vBlank),
		.scanAddr(scanAddr),
		.scanPixel(scanPixel),
		.swapPending(swapPending)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#20 clk = ~clk;
	end

	////////////////////////////////////////
	// Timeout and scan comparison
	////////////////////////////////////////
	always @(posedge clk)
	begin
		cycleCount++;
		if (cycleCount > 2 * (workCycles + 64))	// Slack for reset and vBlank holds
		begin
			$display("Timeout: design stopped making progress after %0d cycles", cycleCount);
			$display("Checks failed");
			$fatal(1);
		end
	end

	always @(posedge clk)
	begin
		checkOn <= scanEnable;	// One cycle read latency
		checkAddr <= scanAddr;
	end

	always @(negedge clk)
	begin
		if (checkOn)
			checkValue($sformatf("%s pixel %0d", testName, checkAddr),
				expectedPixel(checkAddr), scanPixel);
	end

	task automatic checkValue(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected)
		begin
			$display("mismatch %s expected %0h actual %0h", name, expected, actual);
			$display("Checks failed");
			$fatal(1);
		end
	endtask

	////////////////////////////////////////
	// Bus tasks
	////////////////////////////////////////
	task automatic stepCycle();
		@(posedge clk);
		#1;
	endtask

	task automatic pushCmd(input gfxPkg::spanCmd cmd);
		while (cmdFull)
			stepCycle();
		cmdData = cmd;
		cmdPush = 1'b1;
		stepCycle();
		cmdPush = 1'b0;
		applyCmd(cmd);
		// Fetch and decode plus one cycle per pixel
		if (cmd == gfxPkg::swapWord)
			workCycles += 8;
		else
			workCycles += 3 + ((cmd.left <= cmd.right) ? cmd.right - cmd.left + 1 : 0);
	endtask

	task automatic requestSwap();
		pushCmd(gfxPkg::swapWord);
		while (!swapPending)
			stepCycle();
		stepCycle();	// Flip armed in the buffers now
	endtask

	task automatic pulseVBlank();
		vBlank = 1'b1;
		stepCycle();
		vBlank = 1'b0;
		shownSel = 1 - shownSel;
		checkValue({testName, " swapPending after vBlank"}, 0, swapPending);
	endtask

	task automatic swapFrames();
		requestSwap();
		pulseVBlank();
	endtask

	task automatic readRows(input int first, input int last);
		int row;
		int col;
		workCycles += (last - first + 1) * gfxPkg::screenWidth + 2;
		for (row = first; row <= last; row++)
			for (col = 0; col < gfxPkg::screenWidth; col++)
			begin
				scanAddr = 15'(row * gfxPkg::screenWidth + col);
				scanEnable = 1'b1;
				stepCycle();
			end
		scanEnable = 1'b0;
		stepCycle();	// Drain the last compare
	endtask

	////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////
	initial
	begin
		int i;
		int row;
		int left;
		int right;
		int color;
		reset = 1'b1;
		cmdPush = 1'b0;
		cmdData = '0;
		vBlank = 1'b0;
		scanAddr = '0;
		scanEnable = 1'b0;
		repeat (5)
			@(posedge clk);
		#1;
		reset = 1'b0;

		// Memories power up unknown, so both get painted black
		testName = "clear";
		for (i = 0; i < 2; i++)
		begin
			for (row = 0; row < gfxPkg::screenHeight; row++)
				pushCmd(makeSpan(0, row, 0, 159));
			swapFrames();
		end

		testName = "singleSpans";
		pushCmd(makeSpan(1, 10, 5, 20));
		pushCmd(makeSpan(2, 20, 100, 140));
		pushCmd(makeSpan(7, 30, 60, 61));
		swapFrames();
		readRows(9, 31);	// Neighbor rows too

		testName = "edgeSpans";
		pushCmd(makeSpan(5, 50, 77, 77));	// Single pixel
		pushCmd(makeSpan(3, 51, 0, 159));	// Full width
		pushCmd(makeSpan(6, 52, 100, 20));	// Reversed, skipped
		pushCmd(makeSpan(4, 53, 150, 200));
		swapFrames();
		readRows(49, 54);

		testName = "doubleBuffer";
		pushCmd(makeSpan(2, 60, 30, 90));
		readRows(9, 31);		// Front untouched while painting
		readRows(60, 60);
		swapFrames();
		readRows(9, 31);		// Frame from two swaps back
		readRows(60, 60);

		testName = "vBlankWait";
		pushCmd(makeSpan(6, 70, 10, 150));
		requestSwap();
		readRows(70, 70);	// vBlank still low, old front
		checkValue("vBlankWait swapPending held", 1, swapPending);
		pulseVBlank();
		readRows(70, 70);

		testName = "randomFrame";
		for (i = 0; i < 40; i++)
		begin
			row = 80 + nextRandom() % 16;
			left = nextRandom() % 170;	// Some past the right edge
			right = nextRandom() % 170;
			color = nextRandom() % 8;
			pushCmd(makeSpan(color, row, left, right));
		end
		swapFrames();
		readRows(80, 95);

		// Painter parked in waitSwap while the FIFO fills
		testName = "fifoFull";
		requestSwap();
		for (i = 0; i < fifoDepth; i++)
			pushCmd(makeSpan(i % 7 + 1, 100, i * 8, i * 8 + 30));
		checkValue("fifoFull cmdFull", 1, cmdFull);
		pulseVBlank();
		swapFrames();
		readRows(100, 100);	// Overlaps keep the later color

		$display("All checks passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+bench
logic/gfxPkg.sv
logic/spanFifo.sv
logic/spanPainter.sv
logic/frameBuffers.sv
logic/graphicsCore.sv
bench/graphicsCoreTb.sv
